// ==== common/rob_cfg_pkg.sv ====
`default_nettype none

package rob_cfg_pkg;

    // default pool size, overridden from the top level
    parameter int CELLS_DEF  = 24;

    parameter int PAYLOAD_W  = 128;
    parameter int LID_W      = 5;
    parameter int QOS_W      = 2;
    parameter int QOS_LEVELS = 4;

    // counts up to a full pool
    parameter int SEQ_W      = 5;

    // local id plus the port bit
    parameter int ID_W       = LID_W + 1;

endpackage

`default_nettype wire

// ==== common/rob_flit_pkg.sv ====
`default_nettype none

package rob_flit_pkg;

    // full flit id, flat for compares or split by source port
    typedef union packed {
        logic [rob_cfg_pkg::ID_W-1:0] flat;
        struct packed {
            logic                          port_b;
            logic [rob_cfg_pkg::LID_W-1:0] lid;
        } f;
    } flit_id_u;

    typedef struct packed {
        logic [rob_cfg_pkg::PAYLOAD_W-1:0] payload;
        flit_id_u                          id;
        logic [rob_cfg_pkg::QOS_W-1:0]     qos;
    } flit_t;

    // what a cell holds besides its payload
    typedef struct packed {
        flit_id_u                      id;
        logic [rob_cfg_pkg::QOS_W-1:0] qos;
    } cell_tag_t;

endpackage

`default_nettype wire

// ==== cell/rob_cell.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_cell (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              i_wr_a,
    input  logic                              i_wr_b,
    input  rob_flit_pkg::cell_tag_t           i_tag_a,
    input  rob_flit_pkg::cell_tag_t           i_tag_b,
    input  logic [rob_cfg_pkg::SEQ_W-1:0]     i_seq_a,
    input  logic [rob_cfg_pkg::SEQ_W-1:0]     i_seq_b,

    input  logic                              i_free,
    input  logic                              i_rel_en,
    input  rob_flit_pkg::flit_id_u            i_rel_id,

    input  rob_flit_pkg::flit_id_u            i_id_a,
    input  rob_flit_pkg::flit_id_u            i_id_b,

    output logic                              o_valid,
    output logic                              o_eligible,
    output rob_flit_pkg::cell_tag_t           o_tag,
    output logic                              o_match_a,
    output logic                              o_match_b
);

    logic [rob_cfg_pkg::SEQ_W-1:0] seq;
    logic                          rel_hit;
    logic                          keep;

    // an older flit of this id leaves, so move up one place
    assign rel_hit = i_rel_en & o_valid & (i_rel_id.flat == o_tag.id.flat);

    // still holding a flit after this edge
    assign keep = o_valid & ~i_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
            seq     <= '0;
        end else if (i_wr_a) begin
            o_valid <= 1'b1;
            seq     <= i_seq_a;
        end else if (i_wr_b) begin
            o_valid <= 1'b1;
            seq     <= i_seq_b;
        end else if (i_free) begin
            o_valid <= 1'b0;
        end else if (rel_hit) begin
            seq     <= seq - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_a) begin
            o_tag <= i_tag_a;
        end else if (i_wr_b) begin
            o_tag <= i_tag_b;
        end
    end

    // head of its id
    assign o_eligible = o_valid & (seq == '0);

    assign o_match_a = keep & (o_tag.id.flat == i_id_a.flat);
    assign o_match_b = keep & (o_tag.id.flat == i_id_b.flat);

endmodule

`default_nettype wire

// ==== cell/rob_cell_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_cell_array #(
    parameter int CELLS = 24
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  rob_flit_pkg::flit_t                 i_flit_a,
    input  rob_flit_pkg::flit_t                 i_flit_b,
    input  logic                                i_acc_a,
    input  logic                                i_acc_b,
    input  logic [CELLS-1:0]                    i_sel_a,
    input  logic [CELLS-1:0]                    i_sel_b,
    input  logic [CELLS-1:0]                    i_grant,
    input  logic                                i_deliver_en,
    output logic [CELLS-1:0]                    o_valid,
    output logic [CELLS-1:0]                    o_eligible,
    output rob_flit_pkg::cell_tag_t [CELLS-1:0] o_tags,
    output logic [rob_cfg_pkg::SEQ_W-1:0]       o_seq_a,
    output logic [rob_cfg_pkg::SEQ_W-1:0]       o_seq_b
);

    rob_flit_pkg::flit_id_u  id_a;
    rob_flit_pkg::flit_id_u  id_b;
    rob_flit_pkg::flit_id_u  rel_id;
    rob_flit_pkg::cell_tag_t tag_a;
    rob_flit_pkg::cell_tag_t tag_b;
    logic [CELLS-1:0]        match_a;
    logic [CELLS-1:0]        match_b;

    // the port bit completes the full id
    assign id_a.flat = {1'b0, i_flit_a.id.f.lid};
    assign id_b.flat = {1'b1, i_flit_b.id.f.lid};

    assign tag_a = '{id: id_a, qos: i_flit_a.qos};
    assign tag_b = '{id: id_b, qos: i_flit_b.qos};

    always_comb begin
        o_seq_a     = '0;
        o_seq_b     = '0;
        rel_id.flat = '0;
        for (int i = 0; i < CELLS; i++) begin
            o_seq_a     = o_seq_a + rob_cfg_pkg::SEQ_W'(match_a[i]);
            o_seq_b     = o_seq_b + rob_cfg_pkg::SEQ_W'(match_b[i]);
            // grant is one-hot, so the or picks the granted id
            rel_id.flat = rel_id.flat | (o_tags[i].id.flat & {rob_cfg_pkg::ID_W{i_grant[i]}});
        end
    end

    for (genvar c = 0; c < CELLS; c++) begin : g_cell
        rob_cell u_cell (
            .clk        (clk),
            .rst_n      (rst_n),
            .i_wr_a     (i_acc_a & i_sel_a[c]),
            .i_wr_b     (i_acc_b & i_sel_b[c]),
            .i_tag_a    (tag_a),
            .i_tag_b    (tag_b),
            .i_seq_a    (o_seq_a),
            .i_seq_b    (o_seq_b),
            .i_free     (i_grant[c]),
            .i_rel_en   (i_deliver_en),
            .i_rel_id   (rel_id),
            .i_id_a     (id_a),
            .i_id_b     (id_b),
            .o_valid    (o_valid[c]),
            .o_eligible (o_eligible[c]),
            .o_tag      (o_tags[c]),
            .o_match_a  (match_a[c]),
            .o_match_b  (match_b[c])
        );
    end

endmodule

`default_nettype wire

// ==== hdl/rob_admit.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_admit #(
    parameter int CELLS = 24
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_valid_a,
    input  logic             i_valid_b,
    input  logic [CELLS-1:0] i_cell_valid,
    input  logic             i_deliver_en,
    output logic             o_ready_a,
    output logic             o_ready_b,
    output logic             o_acc_a,
    output logic             o_acc_b,
    output logic [CELLS-1:0] o_sel_a,
    output logic [CELLS-1:0] o_sel_b
);

    localparam int CNT_W = $clog2(CELLS + 1);

    logic [CNT_W-1:0] occ;
    logic [CNT_W-1:0] occ_next;
    logic [CELLS-1:0] free_lo;
    logic [CELLS-1:0] free_hi;
    logic             ready_q;

    // A from the bottom, B from the top
    always_comb begin
        free_lo = '0;
        free_hi = '0;
        for (int i = CELLS - 1; i >= 0; i--) begin
            if (!i_cell_valid[i]) begin
                free_lo    = '0;
                free_lo[i] = 1'b1;
            end
        end
        for (int i = 0; i < CELLS; i++) begin
            if (!i_cell_valid[i]) begin
                free_hi    = '0;
                free_hi[i] = 1'b1;
            end
        end
    end

    assign o_acc_a = i_valid_a & ready_q;
    assign o_acc_b = i_valid_b & ready_q;

    assign o_sel_a = free_lo & {CELLS{o_acc_a}};
    assign o_sel_b = free_hi & {CELLS{o_acc_b}};

    assign occ_next = occ + CNT_W'(o_acc_a) + CNT_W'(o_acc_b) - CNT_W'(i_deliver_en);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ     <= '0;
            ready_q <= 1'b0;
        end else begin
            occ     <= occ_next;
            // room for one flit on each port
            ready_q <= (occ_next <= CNT_W'(CELLS - 2));
        end
    end

    assign o_ready_a = ready_q;
    assign o_ready_b = ready_q;

endmodule

`default_nettype wire

// ==== hdl/rob_out_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_out_arbiter #(
    parameter int CELLS = 24
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [CELLS-1:0]                    i_eligible,
    input  rob_flit_pkg::cell_tag_t [CELLS-1:0] i_tags,
    input  logic [rob_cfg_pkg::PAYLOAD_W-1:0]   i_payload,
    input  logic                                i_ready_c,
    output logic [CELLS-1:0]                    o_grant,
    output logic                                o_deliver_en,
    output rob_flit_pkg::flit_t                 o_flit_c,
    output logic                                o_valid_c
);

    logic [rob_cfg_pkg::QOS_LEVELS-1:0] qos_seen;
    logic [rob_cfg_pkg::QOS_W-1:0]      top_qos;
    logic [CELLS-1:0]                   winner;
    logic                               found;
    logic                               load;
    rob_flit_pkg::cell_tag_t            win_tag;

    // which levels are present among the heads
    always_comb begin
        qos_seen = '0;
        for (int i = 0; i < CELLS; i++) begin
            if (i_eligible[i]) begin
                qos_seen[i_tags[i].qos] = 1'b1;
            end
        end
        top_qos = '0;
        for (int q = 0; q < rob_cfg_pkg::QOS_LEVELS; q++) begin
            if (qos_seen[q]) begin
                top_qos = rob_cfg_pkg::QOS_W'(q);
            end
        end
    end

    // lowest index at the top level wins
    always_comb begin
        winner = '0;
        found  = 1'b0;
        for (int i = 0; i < CELLS; i++) begin
            if (!found && i_eligible[i] && (i_tags[i].qos == top_qos)) begin
                winner[i] = 1'b1;
                found     = 1'b1;
            end
        end
    end

    // register empty or draining this edge
    assign load         = found & (~o_valid_c | i_ready_c);
    assign o_grant      = winner & {CELLS{load}};
    assign o_deliver_en = load;

    always_comb begin
        win_tag = '0;
        for (int i = 0; i < CELLS; i++) begin
            win_tag = win_tag | (i_tags[i] & {$bits(win_tag){winner[i]}});
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid_c <= 1'b0;
        end else if (load) begin
            o_valid_c <= 1'b1;
        end else if (i_ready_c) begin
            o_valid_c <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            o_flit_c.payload <= i_payload;
            o_flit_c.id      <= win_tag.id;
            o_flit_c.qos     <= win_tag.qos;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_payload_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_payload_store #(
    parameter int CELLS = 24
) (
    input  logic                              clk,
    input  rob_flit_pkg::flit_t               i_flit_a,
    input  rob_flit_pkg::flit_t               i_flit_b,
    input  logic [CELLS-1:0]                  i_we_a,
    input  logic [CELLS-1:0]                  i_we_b,
    input  logic [CELLS-1:0]                  i_rd_sel,
    output logic [rob_cfg_pkg::PAYLOAD_W-1:0] o_payload
);

    logic [rob_cfg_pkg::PAYLOAD_W-1:0] mem [CELLS];

    // A and B never target the same cell
    for (genvar c = 0; c < CELLS; c++) begin : g_wr
        always_ff @(posedge clk) begin
            if (i_we_a[c]) begin
                mem[c] <= i_flit_a.payload;
            end else if (i_we_b[c]) begin
                mem[c] <= i_flit_b.payload;
            end
        end
    end

    // one-hot read, zero when nothing is selected
    always_comb begin
        o_payload = '0;
        for (int i = 0; i < CELLS; i++) begin
            o_payload = o_payload | (mem[i] & {rob_cfg_pkg::PAYLOAD_W{i_rd_sel[i]}});
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_top #(
    parameter int CELLS = rob_cfg_pkg::CELLS_DEF
) (
    input  logic                clk,
    input  logic                rst_n,

    input  rob_flit_pkg::flit_t i_flit_a,
    input  logic                i_valid_a,
    output logic                o_ready_a,

    input  rob_flit_pkg::flit_t i_flit_b,
    input  logic                i_valid_b,
    output logic                o_ready_b,

    output rob_flit_pkg::flit_t o_flit_c,
    output logic                o_valid_c,
    input  logic                i_ready_c
);

    logic [CELLS-1:0]                   sel_a;
    logic [CELLS-1:0]                   sel_b;
    logic                               acc_a;
    logic                               acc_b;
    logic [CELLS-1:0]                   valid;
    logic [CELLS-1:0]                   eligible;
    rob_flit_pkg::cell_tag_t [CELLS-1:0] tags;
    logic [CELLS-1:0]                   grant;
    logic                               deliver_en;
    logic [rob_cfg_pkg::PAYLOAD_W-1:0]  payload;

    rob_admit #(.CELLS(CELLS)) u_admit (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_valid_a    (i_valid_a),
        .i_valid_b    (i_valid_b),
        .i_cell_valid (valid),
        .i_deliver_en (deliver_en),
        .o_ready_a    (o_ready_a),
        .o_ready_b    (o_ready_b),
        .o_acc_a      (acc_a),
        .o_acc_b      (acc_b),
        .o_sel_a      (sel_a),
        .o_sel_b      (sel_b)
    );

    // same-id counts are only consumed inside the array
    rob_cell_array #(.CELLS(CELLS)) u_cell_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_flit_a     (i_flit_a),
        .i_flit_b     (i_flit_b),
        .i_acc_a      (acc_a),
        .i_acc_b      (acc_b),
        .i_sel_a      (sel_a),
        .i_sel_b      (sel_b),
        .i_grant      (grant),
        .i_deliver_en (deliver_en),
        .o_valid      (valid),
        .o_eligible   (eligible),
        .o_tags       (tags),
        .o_seq_a      (),
        .o_seq_b      ()
    );

    rob_payload_store #(.CELLS(CELLS)) u_payload_store (
        .clk      (clk),
        .i_flit_a (i_flit_a),
        .i_flit_b (i_flit_b),
        .i_we_a   (sel_a),
        .i_we_b   (sel_b),
        .i_rd_sel (grant),
        .o_payload(payload)
    );

    rob_out_arbiter #(.CELLS(CELLS)) u_out_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_eligible   (eligible),
        .i_tags       (tags),
        .i_payload    (payload),
        .i_ready_c    (i_ready_c),
        .o_grant      (grant),
        .o_deliver_en (deliver_en),
        .o_flit_c     (o_flit_c),
        .o_valid_c    (o_valid_c)
    );

endmodule

`default_nettype wire

// ==== test/rob_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_asserts (
    input  logic                clk,
    input  logic                rst_n,
    input  rob_flit_pkg::flit_t i_flit_c,
    input  logic                i_valid_c,
    input  logic                i_ready_c,
    input  logic                i_ready_a,
    input  logic                i_ready_b
);

    // failed checks so far
    int fails = 0;

    // output port holds its flit during a stall
    a_stable_c: assert property (@(posedge clk) disable iff (!rst_n)
        i_valid_c && !i_ready_c |=> $stable(i_flit_c))
        else begin
            fails++;
            $error("output flit changed while port C was stalled");
        end

    a_hold_c: assert property (@(posedge clk) disable iff (!rst_n)
        i_valid_c && !i_ready_c |=> i_valid_c)
        else begin
            fails++;
            $error("output valid dropped without a transfer");
        end

    a_ready_rst: assert property (@(posedge clk)
        !rst_n |-> !i_ready_a && !i_ready_b)
        else begin
            fails++;
            $error("input ready high during reset");
        end

endmodule

`default_nettype wire

// ==== test/rob_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_checker #(
    parameter int CELLS = 24
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [8*12-1:0]     i_test_name,
    input  rob_flit_pkg::flit_t i_flit_a,
    input  logic                i_valid_a,
    input  logic                i_ready_a,
    input  rob_flit_pkg::flit_t i_flit_b,
    input  logic                i_valid_b,
    input  logic                i_ready_b,
    input  rob_flit_pkg::flit_t i_flit_c,
    input  logic                i_valid_c,
    input  logic                i_ready_c,
    output int                  o_mismatches,
    output int                  o_other_errs,
    output int                  o_accepted,
    output int                  o_delivered,
    output int                  o_held
);

    // model of the pool: one entry per cell
    logic                              m_valid [CELLS];
    logic [rob_cfg_pkg::ID_W-1:0]      m_id    [CELLS];
    logic [rob_cfg_pkg::QOS_W-1:0]     m_qos   [CELLS];
    logic [rob_cfg_pkg::PAYLOAD_W-1:0] m_pay   [CELLS];
    int                                m_seq   [CELLS];
    logic                              r_valid;
    rob_flit_pkg::flit_t               r_flit;
    logic                              exp_ready;

    // head of each id with the highest qos, lowest cell on a tie
    function automatic int pick_winner();
        int best;
        best = -1;
        for (int i = 0; i < CELLS; i++) begin
            if (m_valid[i] && m_seq[i] == 0 && (best < 0 || m_qos[i] > m_qos[best])) begin
                best = i;
            end
        end
        return best;
    endfunction

    always @(posedge clk or negedge rst_n) begin : compare
        int                           win;
        int                           slot_a;
        int                           slot_b;
        int                           seq_a;
        int                           seq_b;
        int                           used;
        logic [rob_cfg_pkg::ID_W-1:0] id_a;
        logic [rob_cfg_pkg::ID_W-1:0] id_b;
        logic                         load;
        logic                         xfer_c;
        logic                         acc_a;
        logic                         acc_b;
        if (!rst_n) begin
            for (int i = 0; i < CELLS; i++) begin
                m_valid[i] = 1'b0;
                m_seq[i]   = 0;
            end
            r_valid      = 1'b0;
            exp_ready    = 1'b0;
            o_mismatches = 0;
            o_other_errs = 0;
            o_accepted   = 0;
            o_delivered  = 0;
            o_held       = 0;
        end else begin
            if (i_ready_a !== exp_ready || i_ready_b !== exp_ready) begin
                o_mismatches++;
                $display("Mismatch %0s: readies expected %b actual %b/%b with %0d flits held",
                         i_test_name, exp_ready, i_ready_a, i_ready_b, o_held);
            end
            if (i_valid_c !== r_valid) begin
                if (i_valid_c && o_held == 0) begin
                    o_other_errs++;
                    $display("Error %0s: output valid while no flit is held", i_test_name);
                end else begin
                    o_mismatches++;
                    $display("Mismatch %0s: output valid expected %b actual %b",
                             i_test_name, r_valid, i_valid_c);
                end
            end
            xfer_c = r_valid && i_ready_c;
            if (xfer_c) begin
                o_delivered++;
                if (i_flit_c !== r_flit) begin
                    o_mismatches++;
                    $display("Mismatch %0s: expected %h actual %h",
                             i_test_name, r_flit, i_flit_c);
                end
            end
            win   = pick_winner();
            load  = (win >= 0) && (!r_valid || i_ready_c);
            acc_a = i_valid_a && i_ready_a;
            acc_b = i_valid_b && i_ready_b;
            id_a  = {1'b0, i_flit_a.id.f.lid};
            id_b  = {1'b1, i_flit_b.id.f.lid};
            slot_a = -1;
            slot_b = -1;
            seq_a  = 0;
            seq_b  = 0;
            for (int i = CELLS - 1; i >= 0; i--) begin
                if (!m_valid[i]) slot_a = i;
            end
            for (int i = 0; i < CELLS; i++) begin
                if (!m_valid[i]) slot_b = i;
                if (m_valid[i] && !(load && i == win)) begin
                    if (m_id[i] == id_a) seq_a++;
                    if (m_id[i] == id_b) seq_b++;
                end
            end
            if (load) begin
                r_valid           = 1'b1;
                r_flit.payload    = m_pay[win];
                r_flit.id.flat    = m_id[win];
                r_flit.qos        = m_qos[win];
                m_valid[win]      = 1'b0;
                for (int i = 0; i < CELLS; i++) begin
                    if (m_valid[i] && m_id[i] == m_id[win]) m_seq[i]--;
                end
            end else if (xfer_c) begin
                r_valid = 1'b0;
            end
            if ((acc_a && slot_a < 0) || (acc_b && slot_b < 0) ||
                (acc_a && acc_b && slot_a == slot_b)) begin
                o_other_errs++;
                $display("Error %0s: flit accepted with no free cell", i_test_name);
            end else begin
                if (acc_a) begin
                    m_valid[slot_a] = 1'b1;
                    m_id[slot_a]    = id_a;
                    m_qos[slot_a]   = i_flit_a.qos;
                    m_pay[slot_a]   = i_flit_a.payload;
                    m_seq[slot_a]   = seq_a;
                    o_accepted++;
                end
                if (acc_b) begin
                    m_valid[slot_b] = 1'b1;
                    m_id[slot_b]    = id_b;
                    m_qos[slot_b]   = i_flit_b.qos;
                    m_pay[slot_b]   = i_flit_b.payload;
                    m_seq[slot_b]   = seq_b;
                    o_accepted++;
                end
            end
            used = 0;
            for (int i = 0; i < CELLS; i++) begin
                if (m_valid[i]) used++;
            end
            o_held    = used + (r_valid ? 1 : 0);
            exp_ready = (used <= CELLS - 2);
        end
    end

endmodule

`default_nettype wire

// ==== test/rob_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_tb;

    localparam int CELLS = rob_cfg_pkg::CELLS_DEF;

    logic                clk;
    logic                rst_n;
    rob_flit_pkg::flit_t i_flit_a;
    logic                i_valid_a;
    logic                o_ready_a;
    rob_flit_pkg::flit_t i_flit_b;
    logic                i_valid_b;
    logic                o_ready_b;
    rob_flit_pkg::flit_t o_flit_c;
    logic                o_valid_c;
    logic                i_ready_c;
    logic [8*12-1:0]     test_name;
    logic                xfer_a;
    logic                xfer_b;
    int                  mismatches;
    int                  other_errs;
    int                  accepted;
    int                  delivered;
    int                  held;
    int                  tb_errs;
    int                  cycles;

    rob_top #(.CELLS(CELLS)) i_rob_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_flit_a  (i_flit_a),
        .i_valid_a (i_valid_a),
        .o_ready_a (o_ready_a),
        .i_flit_b  (i_flit_b),
        .i_valid_b (i_valid_b),
        .o_ready_b (o_ready_b),
        .o_flit_c  (o_flit_c),
        .o_valid_c (o_valid_c),
        .i_ready_c (i_ready_c)
    );

    rob_checker #(.CELLS(CELLS)) u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_test_name  (test_name),
        .i_flit_a     (i_flit_a),
        .i_valid_a    (i_valid_a),
        .i_ready_a    (o_ready_a),
        .i_flit_b     (i_flit_b),
        .i_valid_b    (i_valid_b),
        .i_ready_b    (o_ready_b),
        .i_flit_c     (o_flit_c),
        .i_valid_c    (o_valid_c),
        .i_ready_c    (i_ready_c),
        .o_mismatches (mismatches),
        .o_other_errs (other_errs),
        .o_accepted   (accepted),
        .o_delivered  (delivered),
        .o_held       (held)
    );

    bind rob_top rob_asserts u_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_flit_c  (o_flit_c),
        .i_valid_c (o_valid_c),
        .i_ready_c (i_ready_c),
        .i_ready_a (o_ready_a),
        .i_ready_b (o_ready_b)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic rob_flit_pkg::flit_t random_flit(int lid_max);
        rob_flit_pkg::flit_t f;
        f.payload     = {$urandom, $urandom, $urandom, $urandom};
        f.id.f.port_b = 1'($urandom);
        f.id.f.lid    = rob_cfg_pkg::LID_W'($urandom % (lid_max + 1));
        f.qos         = rob_cfg_pkg::QOS_W'($urandom);
        return f;
    endfunction

    // a source keeps its flit until the edge that takes it
    task automatic step_sources(int rate, int lid_max);
        if (!i_valid_a || xfer_a) begin
            i_valid_a = ($urandom % 100) < rate;
            i_flit_a  = random_flit(lid_max);
        end
        if (!i_valid_b || xfer_b) begin
            i_valid_b = ($urandom % 100) < rate;
            i_flit_b  = random_flit(lid_max);
        end
        // readies are registered, so this is the coming edge's outcome
        xfer_a = i_valid_a && o_ready_a;
        xfer_b = i_valid_b && o_ready_b;
    endtask

    task automatic run_traffic(int n, int rate, int lid_max, int ready_pct);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            step_sources(rate, lid_max);
            i_ready_c = ($urandom % 100) < ready_pct;
        end
    endtask

    task automatic stop_sources(int ready_pct);
        while (i_valid_a || i_valid_b) begin
            @(negedge clk);
            step_sources(0, 0);
            i_ready_c = ($urandom % 100) < ready_pct;
        end
    endtask

    task automatic send_flit(logic port, int lid, int qos);
        rob_flit_pkg::flit_t f;
        logic                done;
        f             = random_flit(0);
        f.id.f.port_b = ~port;
        f.id.f.lid    = rob_cfg_pkg::LID_W'(lid);
        f.qos         = rob_cfg_pkg::QOS_W'(qos);
        @(negedge clk);
        xfer_a = 1'b0;
        xfer_b = 1'b0;
        if (!port) begin
            i_flit_a  = f;
            i_valid_a = 1'b1;
        end else begin
            i_flit_b  = f;
            i_valid_b = 1'b1;
        end
        done = 1'b0;
        while (!done) begin
            done = port ? o_ready_b : o_ready_a;
            @(negedge clk);
        end
        if (!port) i_valid_a = 1'b0;
        else i_valid_b = 1'b0;
    endtask

    task automatic wait_drain();
        do @(negedge clk); while (held != 0 || o_valid_c);
    endtask

    // limit grows with the traffic accepted so far
    initial begin
        cycles = 0;
        while (cycles <= 20 * accepted + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run still busy after %0d cycles", cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hed12_2ea3));
        tb_errs   = 0;
        xfer_a    = 1'b0;
        xfer_b    = 1'b0;
        i_flit_a  = '0;
        i_flit_b  = '0;
        i_valid_a = 1'b0;
        i_valid_b = 1'b0;
        i_ready_c = 1'b0;
        test_name = "reset";
        rst_n     = 1'b1;
        #1 rst_n  = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n     = 1'b1;

        test_name = "single";
        i_ready_c = 1'b1;
        send_flit(1'b0, 3, 1);
        wait_drain();
        send_flit(1'b1, 3, 2);
        wait_drain();

        test_name = "same_id";
        run_traffic(300, 50, 3, 70);
        stop_sources(100);
        wait_drain();

        test_name = "qos";
        @(negedge clk);
        i_ready_c = 1'b0;
        send_flit(1'b0, 10, 0);
        send_flit(1'b1, 11, 1);
        send_flit(1'b0, 12, 3);
        send_flit(1'b1, 13, 2);
        @(negedge clk);
        i_ready_c = 1'b1;
        wait_drain();

        test_name = "full";
        run_traffic(60, 100, 7, 0);
        if (o_ready_a || o_ready_b) begin
            tb_errs++;
            $display("Error full: ready still high with port C stalled and the pool full");
        end
        stop_sources(100);
        wait_drain();

        if (accepted != delivered) begin
            tb_errs++;
            $display("Mismatch %0s: expected %0d flits delivered actual %0d",
                     test_name, accepted, delivered);
        end
        $display("errors: mismatch %0d, other %0d, testbench %0d, assertion %0d",
                 mismatches, other_errs, tb_errs, i_rob_top.u_asserts.fails);
        if (mismatches + other_errs + tb_errs + i_rob_top.u_asserts.fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
common/rob_cfg_pkg.sv
common/rob_flit_pkg.sv
cell/rob_cell.sv
cell/rob_cell_array.sv
hdl/rob_admit.sv
hdl/rob_out_arbiter.sv
hdl/rob_payload_store.sv
hdl/rob_top.sv
test/rob_asserts.sv
test/rob_checker.sv
test/rob_tb.sv

// ==== Makefile ====
SHELL := /bin/bash

VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	set -o pipefail; ./$(BIN) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
